//--- logic/soc_pkg.sv
/*
 * System bus package
 * Shared widths, request struct, address map and device table constants
 */
package soc_pkg;

	typedef logic [31:0] data_t;
	typedef logic [13:0] addr_t;
	typedef logic [3:0] sel_t;

	typedef enum logic {
		BUS_READ,
		BUS_WRITE
	} bus_op_e;

	typedef struct packed {
		bus_op_e op;
		addr_t addr;
		data_t data;
		sel_t sel;
	} bus_req_t;

	typedef logic [1:0] slv_idx_t;

	// Slaves in map order, the last one catches everything above the map
	localparam slv_idx_t S_RAM = 2'd0;
	localparam slv_idx_t S_DEVTBL = 2'd1;
	localparam slv_idx_t S_INTCTRL = 2'd2;
	localparam slv_idx_t S_INVALID = 2'd3;
	localparam int SLAVE_COUNT = 4;

	// Map sizes in words
	localparam int MAPSZ_RAM = 256;
	localparam int MAPSZ_DEVTBL = 32;
	localparam int MAPSZ_INTCTRL = 4;

	localparam addr_t BASE_RAM = 14'd0;
	localparam addr_t BASE_DEVTBL = 14'd256;
	localparam addr_t BASE_INTCTRL = 14'd288;
	localparam addr_t BASE_INVALID = BASE_INTCTRL + addr_t'(MAPSZ_INTCTRL);

	// Descriptor contents, element i belongs to slave index i
	localparam logic [SLAVE_COUNT-1:0][7:0] DEV_ID = {8'd0, 8'd3, 8'd7, 8'd1};
	localparam logic [SLAVE_COUNT-1:0] DEV_USEINTR = 4'b0100;

	localparam int INT_SRC_COUNT = 2;
	typedef logic [INT_SRC_COUNT-1:0] irq_vec_t;

	// Software reset register inside the device table
	localparam int RSTCTL_WORD = 31;
	localparam logic [1:0] RST_WARM = 2'd1;
	localparam logic [1:0] RST_PWROFF = 2'd2;

endpackage

//--- logic/rst_seq.sv
/*
 * Reset sequencer
 * Countdown reset, restarted by a warm command, held by the power-off latch
 */
`timescale 1ns/1ps

module rst_seq #(
	parameter int RST_CNT_W = 16
) (
	input  logic clk24mhz,
	input  logic rst_p,
	input  logic [1:0] rst_cmd_i,
	output logic sys_rst_o,
	output logic rst_busy_o
);
	import soc_pkg::*;

	logic [RST_CNT_W-1:0] cnt_q;
	logic off_q;

	always_ff @(posedge clk24mhz) begin
		if (rst_p || rst_cmd_i == RST_WARM)
			cnt_q <= '1;
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;
	end

	// Power-off stays latched until the board reset
	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			off_q <= 1'b0;
		else if (rst_cmd_i == RST_PWROFF)
			off_q <= 1'b1;
	end

	assign rst_busy_o = off_q || (cnt_q != '0);

	// Reset reaches the bus one cycle ahead of busy,
	// so the bus is already quiet on the first busy cycle
	assign sys_rst_o = rst_p || (rst_cmd_i != '0) || rst_busy_o;

endmodule

//--- logic/bus_router.sv
/*
 * Bus router
 * Takes one master request at a time, strobes the addressed slave
 * and returns its answer with a valid/ready handshake
 */
`timescale 1ns/1ps

module bus_router (
	input  logic clk24mhz,
	input  logic rst_p,
	input  logic req_valid_i,
	input  soc_pkg::bus_req_t req_i,
	output logic req_ready_o,
	output logic rsp_valid_o,
	output soc_pkg::data_t rsp_data_o,
	input  logic rsp_ready_i,
	output soc_pkg::bus_req_t slv_req_o,
	output logic [soc_pkg::SLAVE_COUNT-1:0] slv_stb_o,
	input  soc_pkg::data_t ram_data_i,
	input  soc_pkg::data_t devtbl_data_i,
	input  soc_pkg::data_t intctrl_data_i
);
	import soc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_RESPOND
	} state_e;

	state_e state_q;
	bus_req_t req_q;
	slv_idx_t idx_q;
	slv_idx_t dec;
	logic [SLAVE_COUNT-1:0] onehot;
	logic accept;

	function automatic slv_idx_t decode(addr_t a);
		if (a >= BASE_INVALID)
			return S_INVALID;
		if (a >= BASE_INTCTRL)
			return S_INTCTRL;
		if (a >= BASE_DEVTBL)
			return S_DEVTBL;
		return S_RAM;
	endfunction

	assign dec = decode(req_i.addr);
	assign accept = req_valid_i && req_ready_o;

	always_comb begin
		onehot = '0;
		onehot[dec] = 1'b1;
	end

	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			state_q <= ST_IDLE;
			req_ready_o <= 1'b0;
			rsp_valid_o <= 1'b0;
			slv_stb_o <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					req_ready_o <= !accept;
					if (accept) begin
						slv_stb_o <= onehot;
						state_q <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					// Slave samples its strobe here and answers next cycle
					slv_stb_o <= '0;
					rsp_valid_o <= 1'b1;
					state_q <= ST_RESPOND;
				end
				default: begin
					if (rsp_ready_i) begin
						rsp_valid_o <= 1'b0;
						req_ready_o <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (accept) begin
			req_q <= req_i;
			idx_q <= dec;
		end
	end

	assign slv_req_o = req_q;

	// Slaves hold their read word until the next strobe, so the mux is stable
	always_comb begin
		rsp_data_o = '0;
		if (req_q.op == BUS_READ) begin
			case (idx_q)
				S_RAM: rsp_data_o = ram_data_i;
				S_DEVTBL: rsp_data_o = devtbl_data_i;
				S_INTCTRL: rsp_data_o = intctrl_data_i;
				default: rsp_data_o = '0;
			endcase
		end
	end

endmodule

//--- logic/scratch_ram.sv
/*
 * Scratch RAM slave
 * Word memory with byte-select writes and registered reads
 */
`timescale 1ns/1ps

module scratch_ram (
	input  logic clk24mhz,
	input  logic stb_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::data_t data_o
);
	import soc_pkg::*;

	localparam int RAM_AW = $clog2(MAPSZ_RAM);

	data_t mem [MAPSZ_RAM];
	addr_t offs;
	logic [RAM_AW-1:0] widx;

	assign offs = req_i.addr - BASE_RAM;
	assign widx = offs[RAM_AW-1:0];

	always_ff @(posedge clk24mhz) begin
		if (stb_i) begin
			if (req_i.op == BUS_WRITE) begin
				for (int b = 0; b < $bits(sel_t); b++) begin
					if (req_i.sel[b])
						mem[widx][8*b +: 8] <= req_i.data[8*b +: 8];
				end
			end else begin
				data_o <= mem[widx];
			end
		end
	end

endmodule

//--- logic/dev_table.sv
/*
 * Device table slave
 * Read-only id, map size and interrupt flag per slave,
 * plus the software reset register
 */
`timescale 1ns/1ps

module dev_table (
	input  logic clk24mhz,
	input  logic rst_p,
	input  logic stb_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::data_t data_o,
	output logic [1:0] rst_cmd_o
);
	import soc_pkg::*;

	localparam int DT_AW = $clog2(MAPSZ_DEVTBL);

	logic [DT_AW-1:0] word;
	slv_idx_t idx;
	data_t rd_word;
	logic rst_hit;

	function automatic data_t mapsz_of(slv_idx_t s);
		case (s)
			S_RAM: return data_t'(MAPSZ_RAM);
			S_DEVTBL: return data_t'(MAPSZ_DEVTBL);
			S_INTCTRL: return data_t'(MAPSZ_INTCTRL);
			default: return '0;
		endcase
	endfunction

	assign word = DT_AW'(req_i.addr - BASE_DEVTBL);
	assign idx = word[$bits(slv_idx_t):1];

	// Two words per slave: id word first, then map size
	always_comb begin
		rd_word = '0;
		if (int'(word) < 2 * SLAVE_COUNT) begin
			if (!word[0])
				rd_word = {DEV_USEINTR[idx], 23'd0, DEV_ID[idx]};
			else
				rd_word = mapsz_of(idx);
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (stb_i && req_i.op == BUS_READ)
			data_o <= rd_word;
	end

	assign rst_hit = stb_i && req_i.op == BUS_WRITE && word == DT_AW'(RSTCTL_WORD)
		&& (req_i.data == data_t'(RST_WARM) || req_i.data == data_t'(RST_PWROFF));

	// One-cycle command pulse, lines up with the slave's answer
	always_ff @(posedge clk24mhz) begin
		if (rst_p)
			rst_cmd_o <= '0;
		else if (rst_hit)
			rst_cmd_o <= req_i.data[1:0];
		else
			rst_cmd_o <= '0;
	end

endmodule

//--- logic/int_ctrl.sv
/*
 * Interrupt controller slave
 * Pending and enable registers for the interrupt sources, one request line out
 */
`timescale 1ns/1ps

module int_ctrl (
	input  logic clk24mhz,
	input  logic rst_p,
	input  logic stb_i,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::data_t data_o,
	input  soc_pkg::irq_vec_t irq_src_i,
	output logic irq_o
);
	import soc_pkg::*;

	localparam int IC_AW = $clog2(MAPSZ_INTCTRL);

	logic [IC_AW-1:0] word;
	logic wr;
	irq_vec_t pend_q;
	irq_vec_t en_q;
	irq_vec_t clr;

	assign word = IC_AW'(req_i.addr - BASE_INTCTRL);
	assign wr = stb_i && req_i.op == BUS_WRITE;

	// Write one to clear on word 0
	assign clr = (wr && word == IC_AW'(0)) ? req_i.data[INT_SRC_COUNT-1:0] : '0;

	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			pend_q <= '0;
			en_q <= '0;
			irq_o <= 1'b0;
		end else begin
			// A source still high sets its bit again, set beats clear
			pend_q <= (pend_q & ~clr) | irq_src_i;
			if (wr && word == IC_AW'(1))
				en_q <= req_i.data[INT_SRC_COUNT-1:0];
			irq_o <= |(pend_q & en_q);
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (stb_i && req_i.op == BUS_READ) begin
			case (word)
				IC_AW'(0): data_o <= data_t'(pend_q);
				IC_AW'(1): data_o <= data_t'(en_q);
				default: data_o <= '0;
			endcase
		end
	end

endmodule

//--- logic/soc_top.sv
/*
 * System bus top level
 * Master port, router, RAM, device table, interrupt controller and reset sequencer
 */
`timescale 1ns/1ps

module soc_top #(
	parameter int RST_CNT_W = 16
) (
	input  logic clk24mhz,
	input  logic rst_p,
	input  logic req_valid_i,
	input  soc_pkg::bus_req_t req_i,
	output logic req_ready_o,
	output logic rsp_valid_o,
	output soc_pkg::data_t rsp_data_o,
	input  logic rsp_ready_i,
	input  soc_pkg::irq_vec_t irq_src_i,
	output logic irq_o,
	output logic rst_busy_o
);
	import soc_pkg::*;

	logic sys_rst;
	logic [1:0] rst_cmd;
	bus_req_t slv_req;
	logic [SLAVE_COUNT-1:0] slv_stb;
	data_t ram_data;
	data_t devtbl_data;
	data_t intctrl_data;

	rst_seq #(
		.RST_CNT_W(RST_CNT_W)
	) u_rst_seq (
		.clk24mhz(clk24mhz),
		.rst_p(rst_p),
		.rst_cmd_i(rst_cmd),
		.sys_rst_o(sys_rst),
		.rst_busy_o(rst_busy_o)
	);

	bus_router u_router (
		.clk24mhz(clk24mhz),
		.rst_p(sys_rst),
		.req_valid_i(req_valid_i),
		.req_i(req_i),
		.req_ready_o(req_ready_o),
		.rsp_valid_o(rsp_valid_o),
		.rsp_data_o(rsp_data_o),
		.rsp_ready_i(rsp_ready_i),
		.slv_req_o(slv_req),
		.slv_stb_o(slv_stb),
		.ram_data_i(ram_data),
		.devtbl_data_i(devtbl_data),
		.intctrl_data_i(intctrl_data)
	);

	scratch_ram u_ram (
		.clk24mhz(clk24mhz),
		.stb_i(slv_stb[S_RAM]),
		.req_i(slv_req),
		.data_o(ram_data)
	);

	dev_table u_dev_table (
		.clk24mhz(clk24mhz),
		.rst_p(sys_rst),
		.stb_i(slv_stb[S_DEVTBL]),
		.req_i(slv_req),
		.data_o(devtbl_data),
		.rst_cmd_o(rst_cmd)
	);

	int_ctrl u_int_ctrl (
		.clk24mhz(clk24mhz),
		.rst_p(sys_rst),
		.stb_i(slv_stb[S_INTCTRL]),
		.req_i(slv_req),
		.data_o(intctrl_data),
		.irq_src_i(irq_src_i),
		.irq_o(irq_o)
	);

endmodule

//--- tests/soc_assert.sv
/*
 * Bus and reset assertions
 * Bound to the system bus top level
 */
`timescale 1ns/1ps

module soc_assert (
	input logic clk24mhz,
	input logic rst_p,
	input logic sys_rst_i,
	input logic busy_i,
	input logic req_ready_i,
	input logic irq_i,
	input logic rsp_valid_i,
	input soc_pkg::data_t rsp_data_i,
	input logic rsp_ready_i
);

	// Nothing reaches the master while the sequencer is busy
	quiet_in_reset: assert property (@(posedge clk24mhz) disable iff (rst_p)
		busy_i |-> !req_ready_i && !irq_i)
		else $error("req_ready_o or irq_o high while rst_busy_o is high");

	// A stalled response keeps valid and data
	rsp_held: assert property (@(posedge clk24mhz) disable iff (rst_p || sys_rst_i)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
		else $error("response changed before rsp_ready_i");

endmodule

bind soc_top soc_assert u_soc_assert (
	.clk24mhz(clk24mhz),
	.rst_p(rst_p),
	.sys_rst_i(sys_rst),
	.busy_i(rst_busy_o),
	.req_ready_i(req_ready_o),
	.irq_i(irq_o),
	.rsp_valid_i(rsp_valid_o),
	.rsp_data_i(rsp_data_o),
	.rsp_ready_i(rsp_ready_i)
);

//--- tests/tb_soc.sv
/*
 * System bus testbench
 * Acts as the bus master with LFSR stimulus and checks against a model
 */
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int CNT_W = 4;
	localparam int BUSY_LEN = (1 << CNT_W) - 1;
	localparam int MAX_CYCLES = 20000;

	logic clk24mhz = 1'b0;
	logic rst_p;
	logic req_valid_i;
	bus_req_t req_i;
	logic req_ready_o;
	logic rsp_valid_o;
	data_t rsp_data_o;
	logic rsp_ready_i;
	irq_vec_t irq_src_i;
	logic irq_o;
	logic rst_busy_o;

	logic [31:0] lfsr = 32'hb780;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int errors_mark = 0;
	data_t ram_m [MAPSZ_RAM];
	irq_vec_t pend_m;
	irq_vec_t en_m;
	// Sources raised only on the cycle the slave sees its strobe
	irq_vec_t src_pulse = '0;

	soc_top #(
		.RST_CNT_W(CNT_W)
	) dut0 (
		.clk24mhz(clk24mhz),
		.rst_p(rst_p),
		.req_valid_i(req_valid_i),
		.req_i(req_i),
		.req_ready_o(req_ready_o),
		.rsp_valid_o(rsp_valid_o),
		.rsp_data_o(rsp_data_o),
		.rsp_ready_i(rsp_ready_i),
		.irq_src_i(irq_src_i),
		.irq_o(irq_o),
		.rst_busy_o(rst_busy_o)
	);

	always #50 clk24mhz = ~clk24mhz;

	always @(posedge clk24mhz) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Id word then map size word per slave, zero elsewhere
	function automatic data_t descriptor_word(input int w);
		data_t d;
		slv_idx_t s;
		d = '0;
		s = slv_idx_t'(w / 2);
		if (w < 2 * SLAVE_COUNT) begin
			if (w % 2 == 0) begin
				d[7:0] = DEV_ID[s];
				d[31] = DEV_USEINTR[s];
			end else begin
				case (s)
					S_RAM: d = data_t'(MAPSZ_RAM);
					S_DEVTBL: d = data_t'(MAPSZ_DEVTBL);
					S_INTCTRL: d = data_t'(MAPSZ_INTCTRL);
					default: d = '0;
				endcase
			end
		end
		return d;
	endfunction

	task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string msg);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %0t: %s, got %h expected %h", $time, msg, act, exp);
		end
	endtask

	task automatic test_done(input string name);
		$display("%s done, %0d errors", name, errors - errors_mark);
		errors_mark = errors;
	endtask

	task automatic next_cycle();
		@(posedge clk24mhz);
		#5;
	endtask

	task automatic apply_reset();
		int n;
		rst_p = 1'b1;
		repeat (8) next_cycle();
		rst_p = 1'b0;
		n = 0;
		while (rst_busy_o) begin
			check_eq(32'(req_ready_o), 0, "req_ready_o during reset");
			next_cycle();
			n++;
		end
		check_eq(n, BUSY_LEN, "reset length");
	endtask

	// One request and its response, with random idle and optional stalls
	task automatic bus_xfer(input bus_op_e op, input addr_t addr, input data_t data,
		input sel_t sel, input bit stall_ok, output data_t rdata);
		int idle;
		int lat;
		bit acc;
		bit done;
		idle = int'(rand_bits(2));
		repeat (idle) next_cycle();
		req_i.op = op;
		req_i.addr = addr;
		req_i.data = data;
		req_i.sel = sel;
		req_valid_i = 1'b1;
		acc = 1'b0;
		while (!acc) begin
			acc = req_ready_o;
			next_cycle();
		end
		req_valid_i = 1'b0;
		irq_src_i = src_pulse;
		lat = 1;
		while (!rsp_valid_o) begin
			next_cycle();
			irq_src_i = '0;
			lat++;
		end
		rdata = '0;
		done = 1'b0;
		while (!done) begin
			rdata = rsp_data_o;
			rsp_ready_i = stall_ok ? (rand_bits(1) != 0) : 1'b1;
			done = rsp_ready_i;
			next_cycle();
		end
		rsp_ready_i = 1'b0;
		check_eq(lat, 2, "response latency");
		if (op == BUS_WRITE)
			check_eq(rdata, 0, "write response data");
	endtask

	initial begin
		data_t rd;
		data_t d;
		logic [7:0] a;
		addr_t x;
		sel_t sel;
		irq_vec_t hold;
		irq_vec_t clr;
		rst_p = 1'b1;
		req_valid_i = 1'b0;
		req_i = '0;
		rsp_ready_i = 1'b0;
		irq_src_i = '0;
		pend_m = '0;
		en_m = '0;

		apply_reset();
		test_done("reset length");

		// Fill every word first so no read sees unwritten data
		for (int i = 0; i < MAPSZ_RAM; i++) begin
			a = 8'(i);
			d = {a, ~a, a ^ 8'h5a, 8'hc3 - a};
			ram_m[a] = d;
			bus_xfer(BUS_WRITE, BASE_RAM + addr_t'(a), d, 4'hf, 1'b1, rd);
		end
		repeat (64) begin
			a = 8'(rand_bits(8));
			d = rand_bits(32);
			sel = sel_t'(rand_bits(4));
			for (int b = 0; b < 4; b++) begin
				if (sel[b])
					ram_m[a][8*b +: 8] = d[8*b +: 8];
			end
			bus_xfer(BUS_WRITE, BASE_RAM + addr_t'(a), d, sel, 1'b1, rd);
		end
		repeat (64) begin
			a = 8'(rand_bits(8));
			bus_xfer(BUS_READ, BASE_RAM + addr_t'(a), '0, '0, 1'b1, rd);
			check_eq(rd, ram_m[a], "RAM read");
		end
		test_done("scratch RAM");

		for (int w = 0; w < MAPSZ_DEVTBL; w++) begin
			bus_xfer(BUS_READ, BASE_DEVTBL + addr_t'(w), '0, '0, 1'b1, rd);
			check_eq(rd, descriptor_word(w), "descriptor word");
		end
		repeat (32) begin
			x = addr_t'(rand_bits(14));
			if (x < BASE_INVALID)
				x = x + BASE_INVALID;
			bus_xfer(BUS_WRITE, x, rand_bits(32), 4'hf, 1'b1, rd);
			bus_xfer(BUS_READ, x, '0, '0, 1'b1, rd);
			check_eq(rd, 0, "invalid space read");
			a = x[7:0];
			bus_xfer(BUS_READ, BASE_RAM + addr_t'(a), '0, '0, 1'b1, rd);
			check_eq(rd, ram_m[a], "RAM after invalid write");
		end
		test_done("device table and invalid space");

		repeat (16) begin
			hold = irq_vec_t'(rand_bits(2));
			irq_src_i = hold;
			next_cycle();
			irq_src_i = '0;
			pend_m = pend_m | hold;
			en_m = irq_vec_t'(rand_bits(2));
			bus_xfer(BUS_WRITE, BASE_INTCTRL + 14'd1, data_t'(en_m), 4'hf, 1'b1, rd);
			bus_xfer(BUS_READ, BASE_INTCTRL, '0, '0, 1'b1, rd);
			check_eq(rd, data_t'(pend_m), "pending bits");
			next_cycle();
			next_cycle();
			check_eq(32'(irq_o), 32'(|(pend_m & en_m)), "irq_o");
			// Sources high on the clearing cycle keep their bits
			hold = irq_vec_t'(rand_bits(2));
			clr = irq_vec_t'(rand_bits(2));
			src_pulse = hold;
			bus_xfer(BUS_WRITE, BASE_INTCTRL, data_t'(clr), 4'hf, 1'b1, rd);
			src_pulse = '0;
			pend_m = (pend_m & ~clr) | hold;
			bus_xfer(BUS_READ, BASE_INTCTRL + 14'd1, '0, '0, 1'b1, rd);
			check_eq(rd, data_t'(en_m), "enable bits");
		end
		bus_xfer(BUS_READ, BASE_INTCTRL, '0, '0, 1'b1, rd);
		check_eq(rd, data_t'(pend_m), "pending bits after clear");
		test_done("interrupts");

		// Leave interrupt state nonzero so the warm reset has something to clear
		bus_xfer(BUS_WRITE, BASE_INTCTRL + 14'd1, 32'd3, 4'hf, 1'b1, rd);
		irq_src_i = 2'b11;
		next_cycle();
		irq_src_i = '0;
		bus_xfer(BUS_WRITE, BASE_DEVTBL + addr_t'(RSTCTL_WORD), data_t'(RST_WARM),
			4'hf, 1'b0, rd);
		check_eq(32'(rst_busy_o), 1, "rst_busy_o after warm reset");
		while (rst_busy_o)
			next_cycle();
		pend_m = '0;
		en_m = '0;
		bus_xfer(BUS_READ, BASE_INTCTRL, '0, '0, 1'b1, rd);
		check_eq(rd, 0, "pending after warm reset");
		bus_xfer(BUS_READ, BASE_INTCTRL + 14'd1, '0, '0, 1'b1, rd);
		check_eq(rd, 0, "enable after warm reset");
		repeat (16) begin
			a = 8'(rand_bits(8));
			bus_xfer(BUS_READ, BASE_RAM + addr_t'(a), '0, '0, 1'b1, rd);
			check_eq(rd, ram_m[a], "RAM after warm reset");
		end
		test_done("warm reset");

		bus_xfer(BUS_WRITE, BASE_DEVTBL + addr_t'(RSTCTL_WORD), data_t'(RST_PWROFF),
			4'hf, 1'b0, rd);
		repeat (100) begin
			check_eq(32'(rst_busy_o), 1, "rst_busy_o in power-off");
			check_eq(32'(req_ready_o), 0, "req_ready_o in power-off");
			next_cycle();
		end
		apply_reset();
		test_done("power-off");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- flist.f
logic/soc_pkg.sv
logic/rst_seq.sv
logic/bus_router.sv
logic/scratch_ram.sv
logic/dev_table.sv
logic/int_ctrl.sv
logic/soc_top.sv
tests/soc_assert.sv
tests/tb_soc.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc -f flist.f -o sim_tb_soc

# A stopped simulation still counts as a failure through the search below
out=$(./obj_dir/sim_tb_soc 2>&1) || true
echo "$out"
echo "$out" | grep -qx "No errors"
